//--- source/vectorTypesPkg.sv
// Datapath sizes and credit counts; pipeDepth must stay 3 to match the lane's register stages
package vectorTypesPkg;

    // One lane word and the full vector
    localparam int dataWidth = 32;
    localparam int vecLanes = 4;
    localparam int vecWidth = vecLanes * dataWidth;

    // Lane latency, also the length of the drain's valid delay line
    localparam int pipeDepth = 3;

    // Issue queue, equals the producer's starting credits
    localparam int inQueueDepth = 4;
    localparam int inPtrWidth = $clog2(inQueueDepth);
    localparam int inCountWidth = $clog2(inQueueDepth + 1);

    // Drain buffer, equals the issue block's starting credits
    localparam int resultDepth = 4;
    localparam int resultPtrWidth = $clog2(resultDepth);
    localparam int resultCountWidth = $clog2(resultDepth + 1);

    // Downstream credit counter, saturates at its maximum
    localparam int outCreditWidth = 16;

endpackage

//--- source/vectorOpPkg.sv
// Lane operation codes; every lane executes the same operation in a given cycle
package vectorOpPkg;

    localparam int opWidth = 3;

    // Lane-wise operation
    typedef enum logic [opWidth-1:0] {
        opAdd      = 3'd0,
        opSub      = 3'd1,
        // Low 32 bits of the product, same for signed and unsigned
        opMulLow   = 3'd2,
        // High 32 bits, signed operands
        opMulHigh  = 3'd3,
        // High 32 bits, unsigned operands
        opMulHighU = 3'd4
    } vecOp;

endpackage

//--- source/vectorIssue.sv
// Producer must send only while holding a credit, so the queue is never written while full
`timescale 1ns/1ps

module vectorIssue
    import vectorTypesPkg::*;
    import vectorOpPkg::*;
(
    input  logic                clk,
    input  logic                rstN,
    input  logic                inValid,
    input  vecOp                inOp,
    input  logic [vecWidth-1:0] inA,
    input  logic [vecWidth-1:0] inB,
    input  logic                slotFree,
    output logic                inCredit,
    output logic                issueValid,
    output vecOp                issueOp,
    output logic [vecWidth-1:0] issueA,
    output logic [vecWidth-1:0] issueB
);

    // Queue storage
    vecOp                opQueue [inQueueDepth];
    logic [vecWidth-1:0] aQueue [inQueueDepth];
    logic [vecWidth-1:0] bQueue [inQueueDepth];

    logic [inPtrWidth-1:0]       wrPtr;
    logic [inPtrWidth-1:0]       rdPtr;
    logic [inCountWidth-1:0]     queueCount;
    logic [resultCountWidth-1:0] drainCredits;

    logic push;
    logic pop;

    assign push = inValid;
    // Issue only with a queued entry and a free drain slot reserved
    assign pop = (queueCount != '0) && (drainCredits != '0);

    // Pointers, occupancy, drain credits and the issue pulse
    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            queueCount <= '0;
            drainCredits <= resultCountWidth'(resultDepth);
            issueValid <= 1'b0;
            inCredit <= 1'b0;
        end else begin
            if (push) begin
                if (wrPtr == inPtrWidth'(inQueueDepth - 1)) begin
                    wrPtr <= '0;
                end else begin
                    wrPtr <= wrPtr + 1'b1;
                end
            end
            if (pop) begin
                if (rdPtr == inPtrWidth'(inQueueDepth - 1)) begin
                    rdPtr <= '0;
                end else begin
                    rdPtr <= rdPtr + 1'b1;
                end
            end

            case ({push, pop})
                2'b10: queueCount <= queueCount + 1'b1;
                2'b01: queueCount <= queueCount - 1'b1;
                default: queueCount <= queueCount;
            endcase

            // Issuing spends a slot, slotFree hands one back
            case ({pop, slotFree})
                2'b10: drainCredits <= drainCredits - 1'b1;
                2'b01: drainCredits <= drainCredits + 1'b1;
                default: drainCredits <= drainCredits;
            endcase

            // Entry leaving the queue frees a producer credit
            issueValid <= pop;
            inCredit <= pop;
        end
    end

    // Queue write and registered issue operands
    always_ff @(posedge clk) begin
        if (push) begin
            opQueue[wrPtr] <= inOp;
            aQueue[wrPtr] <= inA;
            bQueue[wrPtr] <= inB;
        end
        if (pop) begin
            issueOp <= opQueue[rdPtr];
            issueA <= aQueue[rdPtr];
            issueB <= bQueue[rdPtr];
        end
    end

endmodule

//--- source/vectorLane.sv
// Fixed three-cycle latency with no stall or valid; a new operation is taken every cycle
`timescale 1ns/1ps

module vectorLane
    import vectorTypesPkg::*;
    import vectorOpPkg::*;
(
    input  logic                 clk,
    input  logic                 rstN,
    input  vecOp                 op,
    input  logic [dataWidth-1:0] a,
    input  logic [dataWidth-1:0] b,
    output logic [dataWidth-1:0] result
);

    // Stage 1 operands, one extra bit for signedness
    logic                        signExt;
    logic signed [dataWidth:0]   aExtNext;
    logic signed [dataWidth:0]   bExtNext;
    vecOp                        opR1;
    logic signed [dataWidth:0]   aR1;
    logic signed [dataWidth:0]   bR1;

    // Stage 2 raw results
    logic signed [2*dataWidth+1:0] mulFull;
    logic [dataWidth:0]            addSubNext;
    vecOp                          opR2;
    logic [2*dataWidth-1:0]        prodR2;
    logic [dataWidth-1:0]          sumR2;

    // Stage 3 selection
    logic [dataWidth-1:0] resultNext;

    always_comb begin
        // Only the unsigned high product needs zero extension
        signExt = (op != opMulHighU);
        aExtNext = {signExt & a[dataWidth-1], a};
        bExtNext = {signExt & b[dataWidth-1], b};
    end

    always_comb begin
        mulFull = aR1 * bR1;
        if (opR1 == opSub) begin
            addSubNext = aR1 - bR1;
        end else begin
            addSubNext = aR1 + bR1;
        end
    end

    always_comb begin
        case (opR2)
            opAdd, opSub: resultNext = sumR2;
            opMulLow: resultNext = prodR2[dataWidth-1:0];
            opMulHigh, opMulHighU: resultNext = prodR2[2*dataWidth-1:dataWidth];
            default: resultNext = '0;
        endcase
    end

    // Operation travels alongside its data
    always_ff @(posedge clk) begin
        if (!rstN) begin
            opR1 <= opAdd;
            opR2 <= opAdd;
        end else begin
            opR1 <= op;
            opR2 <= opR1;
        end
    end

    always_ff @(posedge clk) begin
        aR1 <= aExtNext;
        bR1 <= bExtNext;
        prodR2 <= mulFull[2*dataWidth-1:0];
        sumR2 <= addSubNext[dataWidth-1:0];
        result <= resultNext;
    end

endmodule

//--- source/vectorDrain.sv
// Buffer is never written while full because issue holds resultDepth credits for it
`timescale 1ns/1ps

module vectorDrain
    import vectorTypesPkg::*;
(
    input  logic                clk,
    input  logic                rstN,
    input  logic                issueValid,
    input  logic [vecWidth-1:0] laneResult,
    input  logic                outCredit,
    output logic                outValid,
    output logic [vecWidth-1:0] outData,
    output logic                slotFree
);

    // Marks which lane outputs belong to an issued operation
    logic [pipeDepth-1:0] validPipe;

    logic [vecWidth-1:0] resultBuf [resultDepth];

    logic [resultPtrWidth-1:0]   wrPtr;
    logic [resultPtrWidth-1:0]   rdPtr;
    logic [resultCountWidth-1:0] bufCount;
    logic [outCreditWidth-1:0]   outCredits;

    logic write;
    logic pop;

    assign write = validPipe[pipeDepth-1];
    assign pop = (bufCount != '0) && (outCredits != '0);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            validPipe <= '0;
            wrPtr <= '0;
            rdPtr <= '0;
            bufCount <= '0;
            outCredits <= '0;
            outValid <= 1'b0;
            slotFree <= 1'b0;
        end else begin
            validPipe <= {validPipe[pipeDepth-2:0], issueValid};

            if (write) begin
                if (wrPtr == resultPtrWidth'(resultDepth - 1)) begin
                    wrPtr <= '0;
                end else begin
                    wrPtr <= wrPtr + 1'b1;
                end
            end
            if (pop) begin
                if (rdPtr == resultPtrWidth'(resultDepth - 1)) begin
                    rdPtr <= '0;
                end else begin
                    rdPtr <= rdPtr + 1'b1;
                end
            end

            case ({write, pop})
                2'b10: bufCount <= bufCount + 1'b1;
                2'b01: bufCount <= bufCount - 1'b1;
                default: bufCount <= bufCount;
            endcase

            // Credits beyond the counter's range are lost
            case ({outCredit, pop})
                2'b10: begin
                    if (outCredits != '1) begin
                        outCredits <= outCredits + 1'b1;
                    end
                end
                2'b01: outCredits <= outCredits - 1'b1;
                default: outCredits <= outCredits;
            endcase

            // One result out, one slot back to issue
            outValid <= pop;
            slotFree <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            resultBuf[wrPtr] <= laneResult;
        end
        if (pop) begin
            outData <= resultBuf[rdPtr];
        end
    end

endmodule

//--- source/vectorUnitTop.sv
// Credit-based on both sides; lanes never stall, so throughput is bounded only by credits
`timescale 1ns/1ps

module vectorUnitTop
    import vectorTypesPkg::*;
    import vectorOpPkg::*;
(
    input  logic                clk,
    input  logic                rstN,
    input  logic                inValid,
    input  vecOp                inOp,
    input  logic [vecWidth-1:0] inA,
    input  logic [vecWidth-1:0] inB,
    input  logic                outCredit,
    output logic                inCredit,
    output logic                outValid,
    output logic [vecWidth-1:0] outData
);

    logic                issueValid;
    vecOp                issueOp;
    logic [vecWidth-1:0] issueA;
    logic [vecWidth-1:0] issueB;
    logic [vecWidth-1:0] laneResult;
    logic                slotFree;

    vectorIssue issueInst (
        .clk        (clk),
        .rstN       (rstN),
        .inValid    (inValid),
        .inOp       (inOp),
        .inA        (inA),
        .inB        (inB),
        .slotFree   (slotFree),
        .inCredit   (inCredit),
        .issueValid (issueValid),
        .issueOp    (issueOp),
        .issueA     (issueA),
        .issueB     (issueB)
    );

    // Each lane works on its own 32-bit slice
    for (genvar lane = 0; lane < vecLanes; lane++) begin : laneGen
        vectorLane laneInst (
            .clk    (clk),
            .rstN   (rstN),
            .op     (issueOp),
            .a      (issueA[lane*dataWidth +: dataWidth]),
            .b      (issueB[lane*dataWidth +: dataWidth]),
            .result (laneResult[lane*dataWidth +: dataWidth])
        );
    end

    vectorDrain drainInst (
        .clk        (clk),
        .rstN       (rstN),
        .issueValid (issueValid),
        .laneResult (laneResult),
        .outCredit  (outCredit),
        .outValid   (outValid),
        .outData    (outData),
        .slotFree   (slotFree)
    );

endmodule

//--- test/vectorUnitChecker.sv
// Samples the DUT ports on the rising edge; assumes stimulus changes a few ns after the edge
`timescale 1ns/1ps

module vectorUnitChecker
    import vectorTypesPkg::*;
    import vectorOpPkg::*;
(
    input  logic                clk,
    input  logic                rstN,
    input  logic                inValid,
    input  vecOp                inOp,
    input  logic [vecWidth-1:0] inA,
    input  logic [vecWidth-1:0] inB,
    input  logic                outValid,
    input  logic [vecWidth-1:0] outData,
    output int                  errorCount,
    output int                  pendingCount
);

    logic [vecWidth-1:0] expQ [$];

    // Reference result of one lane, straight from the operation rules
    function automatic logic [dataWidth-1:0] laneModel(vecOp op, logic [31:0] a, logic [31:0] b);
        logic [63:0] prodU;
        longint      prodS;
        prodU = {32'd0, a} * {32'd0, b};
        prodS = longint'($signed(a)) * longint'($signed(b));
        case (op)
            opAdd: return a + b;
            opSub: return a - b;
            opMulLow: return prodU[31:0];
            opMulHigh: return prodS[63:32];
            opMulHighU: return prodU[63:32];
            default: return '0;
        endcase
    endfunction

    function automatic logic [vecWidth-1:0] vectorModel(vecOp op, logic [vecWidth-1:0] a,
                                                        logic [vecWidth-1:0] b);
        logic [vecWidth-1:0] vec;
        for (int lane = 0; lane < vecLanes; lane++) begin
            vec[lane*dataWidth +: dataWidth] = laneModel(op, a[lane*dataWidth +: dataWidth],
                                                         b[lane*dataWidth +: dataWidth]);
        end
        return vec;
    endfunction

    initial begin
        errorCount = 0;
        pendingCount = 0;
    end

    always @(posedge clk) begin
        logic [vecWidth-1:0] expected;
        if (!rstN) begin
            expQ.delete();
        end else begin
            if (outValid) begin
                if (expQ.size() == 0) begin
                    $display("Result arrived with no operation outstanding");
                    errorCount++;
                end else begin
                    expected = expQ.pop_front();
                    if (outData !== expected) begin
                        $display("[FAIL] outData expected %h received %h", expected, outData);
                        errorCount++;
                    end
                end
            end
            if (inValid) begin
                expQ.push_back(vectorModel(inOp, inA, inB));
            end
        end
        pendingCount = expQ.size();
    end

endmodule

//--- test/vectorUnit_asserts.sv
// Bound to vectorUnitTop; assumes one outValid pulse consumes exactly one outCredit
`timescale 1ns/1ps

module vectorUnitAsserts
    import vectorTypesPkg::*;
(
    input logic                clk,
    input logic                rstN,
    input logic                inCredit,
    input logic                outValid,
    input logic                outCredit,
    input logic [vecWidth-1:0] outData
);

    // Downstream credits granted but not yet used
    int heldCredits;

    always @(posedge clk) begin
        if (!rstN) begin
            heldCredits <= 0;
        end else begin
            heldCredits <= heldCredits + (outCredit ? 1 : 0) - (outValid ? 1 : 0);
        end
    end

    quietAfterReset: assert property (@(posedge clk) !rstN |=> (!inCredit && !outValid))
        else $error("inCredit or outValid high during or right after reset");

    creditBeforeValid: assert property (@(posedge clk) disable iff (!rstN)
        outValid |-> (heldCredits > 0))
        else $error("outValid without an unspent outCredit");

    knownData: assert property (@(posedge clk) disable iff (!rstN)
        outValid |-> !$isunknown(outData))
        else $error("outData has X or Z while outValid is high");

endmodule

bind vectorUnitTop vectorUnitAsserts creditChecks (.*);

//--- test/vectorUnitTb.sv
// Producer side honors inQueueDepth credits; outCredit pacing changes per phase
`timescale 1ns/1ps

module vectorUnitTb;
    import vectorTypesPkg::*;
    import vectorOpPkg::*;

    localparam int numEntries = 8;
    localparam int waitLimit = 500;

    logic                clk;
    logic                rstN;
    logic                inValid;
    vecOp                inOp;
    logic [vecWidth-1:0] inA;
    logic [vecWidth-1:0] inB;
    logic                outCredit;
    logic                inCredit;
    logic                outValid;
    logic [vecWidth-1:0] outData;

    int checkErrors;
    int pendingCount;
    int tbErrors = 0;
    int creditsReturned;
    int creditsSpent = 0;
    int resultIndex;
    // 0 none, 1 full rate, 2 random 30 %, 3 hold 50 cycles then full
    int creditMode = 0;
    int holdCount = 0;

    vecOp                tableOp [numEntries];
    logic [vecWidth-1:0] tableA [numEntries];
    logic [vecWidth-1:0] tableB [numEntries];
    logic [vecWidth-1:0] tableExp [numEntries];

    vectorUnitTop uut (.*);

    vectorUnitChecker checkerInst (
        .clk          (clk),
        .rstN         (rstN),
        .inValid      (inValid),
        .inOp         (inOp),
        .inA          (inA),
        .inB          (inB),
        .outValid     (outValid),
        .outData      (outData),
        .errorCount   (checkErrors),
        .pendingCount (pendingCount)
    );

    always #20 clk = ~clk;

    function automatic int creditsHeld();
        return inQueueDepth + creditsReturned - creditsSpent;
    endfunction

    task automatic addEntry(int idx, vecOp op, logic [vecWidth-1:0] a, logic [vecWidth-1:0] b,
                            logic [vecWidth-1:0] exp);
        tableOp[idx] = op;
        tableA[idx] = a;
        tableB[idx] = b;
        tableExp[idx] = exp;
    endtask

    // Lanes listed high to low
    task automatic loadTable();
        addEntry(0, opAdd, {32'hFFFFFFFF, 32'h7FFFFFFF, 32'h00000001, 32'h80000000},
                 {32'h00000001, 32'h00000001, 32'hFFFFFFFF, 32'h80000000},
                 {32'h00000000, 32'h80000000, 32'h00000000, 32'h00000000});
        addEntry(1, opSub, {32'h00000000, 32'h80000000, 32'h00000005, 32'h12345678},
                 {32'h00000001, 32'h00000001, 32'h00000007, 32'h12345678},
                 {32'hFFFFFFFF, 32'h7FFFFFFF, 32'hFFFFFFFE, 32'h00000000});
        addEntry(2, opMulLow, {32'hFFFFFFFF, 32'h00010000, 32'h00000003, 32'h12345678},
                 {32'hFFFFFFFF, 32'h00010000, 32'h00000005, 32'h00000000},
                 {32'h00000001, 32'h00000000, 32'h0000000F, 32'h00000000});
        addEntry(3, opMulHigh, {32'hFFFFFFFF, 32'h80000000, 32'hFFFFFFFE, 32'h7FFFFFFF},
                 {32'hFFFFFFFF, 32'h80000000, 32'h00000003, 32'h7FFFFFFF},
                 {32'h00000000, 32'h40000000, 32'hFFFFFFFF, 32'h3FFFFFFF});
        addEntry(4, opMulHighU, {32'hFFFFFFFF, 32'h80000000, 32'hFFFFFFFE, 32'h7FFFFFFF},
                 {32'hFFFFFFFF, 32'h80000000, 32'h00000003, 32'h7FFFFFFF},
                 {32'hFFFFFFFE, 32'h40000000, 32'h00000002, 32'h3FFFFFFF});
        addEntry(5, opAdd, '0, '0, '0);
        addEntry(6, opAdd, '1, '1, {4{32'hFFFFFFFE}});
        addEntry(7, opSub, '1, '0, '1);
    endtask

    // Called 2 ns after an edge; leaves inValid high for exactly one edge
    task automatic sendOp(vecOp op, logic [vecWidth-1:0] a, logic [vecWidth-1:0] b);
        int waits;
        waits = 0;
        while (creditsHeld() == 0 && waits < waitLimit) begin
            inValid = 1'b0;
            @(posedge clk);
            #2;
            waits++;
        end
        if (creditsHeld() == 0) begin
            $display("Timed out waiting for an upstream credit");
            tbErrors++;
        end else begin
            inValid = 1'b1;
            inOp = op;
            inA = a;
            inB = b;
            creditsSpent++;
            @(posedge clk);
            #2;
            inValid = 1'b0;
        end
    endtask

    always @(posedge clk) begin
        if (!rstN) begin
            creditsReturned <= 0;
        end else if (inCredit) begin
            creditsReturned <= creditsReturned + 1;
        end
        if (rstN && creditsHeld() > inQueueDepth) begin
            $display("More upstream credits came back than were spent");
            tbErrors++;
        end
    end

    // Table results are also checked against their hand-computed values
    always @(posedge clk) begin
        if (!rstN) begin
            resultIndex <= 0;
        end else if (outValid && resultIndex < numEntries) begin
            if (outData !== tableExp[resultIndex]) begin
                $display("[FAIL] outData expected %h received %h", tableExp[resultIndex], outData);
                tbErrors++;
            end
            resultIndex <= resultIndex + 1;
        end
    end

    // Pacing is decided on the edge and driven 2 ns later
    always @(posedge clk) begin
        logic creditNext;
        if (creditMode != 3) begin
            holdCount = 0;
        end
        case (creditMode)
            1: creditNext = 1'b1;
            2: creditNext = (($urandom % 100) < 30);
            3: begin
                creditNext = (holdCount >= 50);
                if (holdCount < 50) begin
                    holdCount++;
                end
            end
            default: creditNext = 1'b0;
        endcase
        #2;
        outCredit = creditNext;
    end

    initial begin
        int waits;
        void'($urandom(50504));
        clk = 1'b0;
        rstN = 1'b0;
        inValid = 1'b0;
        inOp = opAdd;
        inA = '0;
        inB = '0;
        outCredit = 1'b0;
        loadTable();
        repeat (5) @(posedge clk);
        #2;
        rstN = 1'b1;
        // Nothing may come out before input and credits arrive
        repeat (4) begin
            @(posedge clk);
            #2;
            if (outValid || inCredit) begin
                $display("outValid or inCredit rose before any input or credit");
                tbErrors++;
            end
        end
        creditMode = 1;
        for (int i = 0; i < numEntries; i++) begin
            sendOp(tableOp[i], tableA[i], tableB[i]);
        end
        creditMode = 2;
        for (int i = 0; i < 200; i++) begin
            if (i == 100) begin
                creditMode = 3;
            end
            sendOp(vecOp'(3'($urandom % 5)), {$urandom, $urandom, $urandom, $urandom},
                   {$urandom, $urandom, $urandom, $urandom});
        end
        creditMode = 1;
        waits = 0;
        while ((pendingCount != 0 || creditsHeld() != inQueueDepth) && waits < 1000) begin
            @(posedge clk);
            #2;
            waits++;
        end
        if (pendingCount != 0) begin
            $display("Timed out with %0d results never delivered", pendingCount);
            tbErrors++;
        end else if (creditsHeld() != inQueueDepth) begin
            $display("Upstream credits did not all return by the end");
            tbErrors++;
        end
        $display("Errors: testbench %0d, checker %0d", tbErrors, checkErrors);
        if (tbErrors + checkErrors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- flist.f
source/vectorTypesPkg.sv
source/vectorOpPkg.sv
source/vectorIssue.sv
source/vectorLane.sv
source/vectorDrain.sv
source/vectorUnitTop.sv
test/vectorUnitChecker.sv
test/vectorUnit_asserts.sv
test/vectorUnitTb.sv

//--- Makefile
SOURCES = $(shell cat flist.f)

.PHONY: run clean

run: obj_dir/VvectorUnitTb
	./obj_dir/VvectorUnitTb | tee /dev/stderr | grep -qF '*** TEST PASSED ***'

obj_dir/VvectorUnitTb: flist.f $(SOURCES)
	verilator --binary --timing --assert --top-module vectorUnitTb -f flist.f

clean:
	rm -rf obj_dir
